// ==== rv_pkg.sv ====
// shared encodings for the rv64i core, imported by the decoder, alu, memory, csr and execution rtl
package rv_pkg;

	// major opcodes
	localparam logic [6:0] OP_LUI      = 7'b0110111;
	localparam logic [6:0] OP_AUIPC    = 7'b0010111;
	localparam logic [6:0] OP_JAL      = 7'b1101111;
	localparam logic [6:0] OP_JALR     = 7'b1100111;
	localparam logic [6:0] OP_BRANCH   = 7'b1100011;
	localparam logic [6:0] OP_LOAD     = 7'b0000011;
	localparam logic [6:0] OP_STORE    = 7'b0100011;
	localparam logic [6:0] OP_IMM      = 7'b0010011;
	localparam logic [6:0] OP_OP       = 7'b0110011;
	localparam logic [6:0] OP_IMM_32   = 7'b0011011;
	localparam logic [6:0] OP_32       = 7'b0111011;
	localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OP_SYSTEM   = 7'b1110011;

	// branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// load / store sizes
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_D  = 3'b011;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;
	localparam logic [2:0] F3_WU = 3'b110;

	// csr ops, bit 2 picks the zimm form
	localparam logic [2:0] F3_CSRRW  = 3'b001;
	localparam logic [2:0] F3_CSRRS  = 3'b010;
	localparam logic [2:0] F3_CSRRC  = 3'b011;
	localparam logic [2:0] F3_CSRRWI = 3'b101;
	localparam logic [2:0] F3_CSRRSI = 3'b110;
	localparam logic [2:0] F3_CSRRCI = 3'b111;

	// alu function, same encoding as funct3 of OP / OP-IMM
	typedef enum logic [2:0] {
		SEL_ADD  = 3'b000,
		SEL_SLL  = 3'b001,
		SEL_SLT  = 3'b010,
		SEL_SLTU = 3'b011,
		SEL_XOR  = 3'b100,
		SEL_SR   = 3'b101,
		SEL_OR   = 3'b110,
		SEL_AND  = 3'b111
	} alu_sel_t;

	localparam logic [11:0] CSR_MTVEC  = 12'h305;
	localparam logic [11:0] CSR_MEPC   = 12'h341;
	localparam logic [11:0] CSR_MCAUSE = 12'h342;

	localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INST_MRET   = 32'h3020_0073;

	localparam int CAUSE_ECALL_M = 11; // environment call from m-mode

endpackage

// ==== rv_idu.sv ====
// instruction decoder, splits the fetched word into fields and the sign-extended immediate
`timescale 1ns/1ps

module rv_idu #(
	parameter int XLEN = 64
) (
	input  logic [31:0]     inst,
	output logic [6:0]      opcode,
	output logic [2:0]      funct3,
	output logic [6:0]      funct7,
	output logic [4:0]      rs1,
	output logic [4:0]      rs2,
	output logic [4:0]      rd,
	output logic [XLEN-1:0] imm
);
	import rv_pkg::*;

	logic signed [11:0] imm_i;
	logic signed [11:0] imm_s;
	logic signed [12:0] imm_b;
	logic signed [31:0] imm_u;
	logic signed [20:0] imm_j;

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign funct7 = inst[31:25];

	// raw immediates per format, extended below
	assign imm_i = inst[31:20];
	assign imm_s = {inst[31:25], inst[11:7]};
	assign imm_b = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (opcode)
			OP_LUI, OP_AUIPC: imm = XLEN'(imm_u);
			OP_JAL:           imm = XLEN'(imm_j);
			OP_BRANCH:        imm = XLEN'(imm_b);
			OP_STORE:         imm = XLEN'(imm_s);
			OP_JALR, OP_LOAD, OP_IMM, OP_IMM_32, OP_SYSTEM: begin
				imm = XLEN'(imm_i); // csr address sits in imm[11:0]
			end
			default:          imm = '0; // R-type and fence
		endcase
	end

endmodule

// ==== rv_alu.sv ====
// combinational alu with add/sub, shifts, logic and compare flags, plus rv64 word mode
`timescale 1ns/1ps

module rv_alu #(
	parameter int XLEN = 64
) (
	input  rv_pkg::alu_sel_t sel,
	input  logic [XLEN-1:0]  a,
	input  logic [XLEN-1:0]  b,
	input  logic             sub_sra,
	input  logic             word_op,
	output logic [XLEN-1:0]  result,
	output logic             equal,
	output logic             less_s,
	output logic             less_u
);
	import rv_pkg::*;

	localparam int SHW = $clog2(XLEN);

	logic [SHW-1:0]  shamt;
	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] sr_a; // right shift operand
	logic [XLEN-1:0] raw;

	assign sum   = sub_sra ? a - b : a + b;
	assign shamt = word_op ? SHW'(b[4:0]) : b[SHW-1:0];

	// word shifts only see the low half, extended by shift kind
	always_comb begin
		if (!word_op)
			sr_a = a;
		else if (sub_sra)
			sr_a = XLEN'(signed'(a[31:0]));
		else
			sr_a = XLEN'(a[31:0]);
	end

	// flags on full operands
	assign equal  = a == b;
	assign less_s = $signed(a) < $signed(b);
	assign less_u = a < b;

	always_comb begin
		case (sel)
			SEL_ADD:  raw = sum;
			SEL_SLL:  raw = a << shamt;
			SEL_SLT:  raw = XLEN'(less_s);
			SEL_SLTU: raw = XLEN'(less_u);
			SEL_XOR:  raw = a ^ b;
			SEL_SR:   raw = sub_sra ? XLEN'($signed(sr_a) >>> shamt) : sr_a >> shamt;
			SEL_OR:   raw = a | b;
			SEL_AND:  raw = a & b;
			default:  raw = '0;
		endcase
	end

	assign result = word_op ? XLEN'(signed'(raw[31:0])) : raw; // sext low word
endmodule

// ==== rv_csr_file.sv ====
// machine-mode csr registers, takes the ecall trap and supplies the trap or return target
`timescale 1ns/1ps

module rv_csr_file #(
	parameter int              XLEN        = 64,
	parameter logic [XLEN-1:0] MTVEC_RESET = 'h100
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            wen,
	input  logic [11:0]     addr,
	input  logic [XLEN-1:0] wdata,
	input  logic            ecall,
	input  logic            mret,
	input  logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] csr_rdata,
	output logic [XLEN-1:0] trap_target
);
	import rv_pkg::*;

	logic [XLEN-1:0] mtvec;
	logic [XLEN-1:0] mepc;
	logic [XLEN-1:0] mcause;

	always_ff @(posedge clk) begin
		if (reset) begin
			mtvec  <= MTVEC_RESET;
			mepc   <= '0;
			mcause <= '0;
		end else if (ecall) begin
			mepc   <= pc; // trap entry
			mcause <= XLEN'(CAUSE_ECALL_M);
		end else if (wen) begin
			case (addr)
				CSR_MTVEC:  mtvec  <= wdata;
				CSR_MEPC:   mepc   <= wdata;
				CSR_MCAUSE: mcause <= wdata;
				default: ; // unimplemented csr, write dropped
			endcase
		end
	end

	always_comb begin
		case (addr)
			CSR_MTVEC:  csr_rdata = mtvec;
			CSR_MEPC:   csr_rdata = mepc;
			CSR_MCAUSE: csr_rdata = mcause;
			default:    csr_rdata = '0;
		endcase
	end

	// mret returns to mepc, ecall enters at mtvec
	assign trap_target = mret ? mepc : mtvec;

endmodule

// ==== rv_mau.sv ====
// data memory access unit with sized, extended loads and byte-masked stores
`timescale 1ns/1ps

module rv_mau #(
	parameter int XLEN      = 64,
	parameter int MEM_WORDS = 256
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            load,
	input  logic            store,
	input  logic [2:0]      funct3,
	input  logic [XLEN-1:0] addr,
	input  logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rdata
);
	import rv_pkg::*;

	localparam int AW = $clog2(MEM_WORDS);

	logic [63:0]   mem [MEM_WORDS];
	logic [AW-1:0] idx;
	logic [2:0]    off;        // byte offset in the word
	logic [63:0]   rd_line;
	logic [63:0]   wr_line;
	logic [7:0]    size_mask;
	logic [7:0]    byte_en;

	assign idx     = addr[AW+2:3];
	assign off     = addr[2:0];
	assign rd_line = mem[idx] >> {off, 3'b000};
	assign wr_line = 64'(wdata) << {off, 3'b000};

	always_comb begin
		case (funct3)
			F3_B:    size_mask = 8'h01;
			F3_H:    size_mask = 8'h03;
			F3_W:    size_mask = 8'h0f;
			default: size_mask = 8'hff; // sd
		endcase
	end
	assign byte_en = size_mask << off;

	always_comb begin
		case (funct3)
			F3_B:    rdata = XLEN'(signed'(rd_line[7:0]));
			F3_H:    rdata = XLEN'(signed'(rd_line[15:0]));
			F3_W:    rdata = XLEN'(signed'(rd_line[31:0]));
			F3_D:    rdata = XLEN'(rd_line);
			F3_BU:   rdata = XLEN'(rd_line[7:0]);
			F3_HU:   rdata = XLEN'(rd_line[15:0]);
			F3_WU:   rdata = XLEN'(rd_line[31:0]);
			default: rdata = '0;
		endcase
		if (!load)
			rdata = '0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < MEM_WORDS; w++)
				mem[w] <= '0;
		end else if (store) begin
			for (int i = 0; i < 8; i++)
				if (byte_en[i])
					mem[idx][i*8 +: 8] <= wr_line[i*8 +: 8];
		end
	end
endmodule

// ==== rv_exu.sv ====
// execution unit, operand and alu select, branch and next pc, write-back and csr control
`timescale 1ns/1ps

module rv_exu #(
	parameter int              XLEN        = 64,
	parameter int              MEM_WORDS   = 256,
	parameter logic [XLEN-1:0] MTVEC_RESET = 'h100
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            halted,
	input  logic [31:0]     inst,
	input  logic [6:0]      opcode,
	input  logic [2:0]      funct3,
	input  logic [6:0]      funct7,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rd,
	input  logic [XLEN-1:0] imm,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [XLEN-1:0] pc,
	output logic            rd_wen,
	output logic [XLEN-1:0] x_rd,
	output logic [XLEN-1:0] dnpc,
	output logic            is_ebreak
);
	import rv_pkg::*;

	alu_sel_t        alu_sel;
	logic [XLEN-1:0] alu_a;
	logic [XLEN-1:0] alu_b;
	logic            alu_sub_sra;
	logic            word_op;
	logic [XLEN-1:0] alu_result;
	logic            equal;
	logic            less_s;
	logic            less_u;
	logic            branch_taken;
	logic [XLEN-1:0] jalr_sum;
	logic [XLEN-1:0] load_data;
	logic            is_ecall;
	logic            is_mret;
	logic            is_csr;
	logic            csr_wen;
	logic [XLEN-1:0] csr_src;   // rs1 value or zimm
	logic [XLEN-1:0] csr_rdata;
	logic [XLEN-1:0] trap_target;
	logic            rd_wen_raw;

	assign is_ecall  = inst == INST_ECALL;
	assign is_mret   = inst == INST_MRET;
	assign is_ebreak = inst == INST_EBREAK;
	assign is_csr    = (opcode == OP_SYSTEM) && (funct3 != 3'b000);
	assign csr_src   = funct3[2] ? XLEN'(rs1) : src1;
	assign word_op   = (opcode == OP_IMM_32) || (opcode == OP_32);

	// set / clear with rs1 = x0 must not write the csr
	assign csr_wen = is_csr && !halted
		&& (funct3 == F3_CSRRW || funct3 == F3_CSRRWI || rs1 != 5'd0);

	always_comb begin
		alu_sel     = SEL_ADD;
		alu_a       = src1;
		alu_b       = imm;  // also the load/store address
		alu_sub_sra = 1'b0;
		case (opcode)
			OP_LUI:   alu_a = '0;
			OP_AUIPC: alu_a = pc;
			OP_JAL, OP_JALR: begin
				alu_a = pc; // link value
				alu_b = XLEN'(4);
			end
			OP_BRANCH: alu_b = src2; // flags only
			OP_IMM, OP_IMM_32: begin
				alu_sel     = alu_sel_t'(funct3);
				alu_sub_sra = (alu_sel_t'(funct3) == SEL_SR) && funct7[5];
			end
			OP_OP, OP_32: begin
				alu_sel     = alu_sel_t'(funct3);
				alu_b       = src2;
				alu_sub_sra = funct7[5];
			end
			OP_SYSTEM: begin
				alu_a = csr_src;
				alu_b = '0;
				if (funct3 == F3_CSRRS || funct3 == F3_CSRRSI) begin
					alu_sel = SEL_OR;
					alu_b   = csr_rdata;
				end else if (funct3 == F3_CSRRC || funct3 == F3_CSRRCI) begin
					alu_sel = SEL_AND; // csr & ~mask
					alu_a   = ~csr_src;
					alu_b   = csr_rdata;
				end
			end
			default: ;
		endcase
	end

	rv_alu #(.XLEN(XLEN)) alu_i (
		.sel     (alu_sel),
		.a       (alu_a),
		.b       (alu_b),
		.sub_sra (alu_sub_sra),
		.word_op (word_op),
		.result  (alu_result),
		.equal   (equal),
		.less_s  (less_s),
		.less_u  (less_u)
	);

	rv_mau #(.XLEN(XLEN), .MEM_WORDS(MEM_WORDS)) mau_i (
		.clk    (clk),
		.reset  (reset),
		.load   (opcode == OP_LOAD),
		.store  ((opcode == OP_STORE) && !halted),
		.funct3 (funct3),
		.addr   (alu_result),
		.wdata  (src2),
		.rdata  (load_data)
	);

	rv_csr_file #(.XLEN(XLEN), .MTVEC_RESET(MTVEC_RESET)) csr_i (
		.clk         (clk),
		.reset       (reset),
		.wen         (csr_wen),
		.addr        (imm[11:0]),
		.wdata       (alu_result),
		.ecall       (is_ecall && !halted),
		.mret        (is_mret),
		.pc          (pc),
		.csr_rdata   (csr_rdata),
		.trap_target (trap_target)
	);

	always_comb begin
		case (funct3)
			F3_BEQ:  branch_taken = equal;
			F3_BNE:  branch_taken = !equal;
			F3_BLT:  branch_taken = less_s;
			F3_BGE:  branch_taken = !less_s;
			F3_BLTU: branch_taken = less_u;
			F3_BGEU: branch_taken = !less_u;
			default: branch_taken = 1'b0;
		endcase
	end

	assign jalr_sum = src1 + imm;

	always_comb begin
		dnpc = pc + XLEN'(4);
		case (opcode)
			OP_JAL:    dnpc = pc + imm;
			OP_JALR:   dnpc = {jalr_sum[XLEN-1:1], 1'b0};
			OP_BRANCH: if (branch_taken) dnpc = pc + imm;
			OP_SYSTEM: if (is_ecall || is_mret) dnpc = trap_target;
			default: ;
		endcase
	end

	always_comb begin
		rd_wen_raw = 1'b0;
		x_rd       = alu_result;
		case (opcode)
			OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_IMM, OP_OP: rd_wen_raw = 1'b1;
			OP_IMM_32, OP_32: rd_wen_raw = XLEN > 32; // no word ops on rv32
			OP_LOAD: begin
				rd_wen_raw = 1'b1;
				x_rd       = load_data;
			end
			OP_SYSTEM: begin
				rd_wen_raw = is_csr && (rd != 5'd0); // old csr value to rd
				x_rd       = csr_rdata;
			end
			OP_MISC_MEM: rd_wen_raw = 1'b0; // fence is a no-op
			default: x_rd = '0;
		endcase
	end

	assign rd_wen = rd_wen_raw && !halted;
endmodule

// ==== rv_arch_state.sv ====
// register file with x0 tied to zero, program counter and halt flag that rv_core updates each commit
`timescale 1ns/1ps

module rv_arch_state #(
	parameter int XLEN = 64
) (
	input  logic            clk,
	input  logic            reset,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  logic [4:0]      rd,
	input  logic            rd_wen,
	input  logic            halt_now,
	input  logic [XLEN-1:0] x_rd,
	input  logic [XLEN-1:0] dnpc,
	output logic [XLEN-1:0] src1,
	output logic [XLEN-1:0] src2,
	output logic [XLEN-1:0] pc,
	output logic            halted
);
	logic [XLEN-1:0] regs [1:31]; // x1..x31

	assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (rd_wen && rd != 5'd0) begin
			regs[rd] <= x_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc     <= '0;
			halted <= 1'b0;
		end else begin
			if (!halted && !halt_now)
				pc <= dnpc; // ebreak leaves pc at its own address
			if (halt_now)
				halted <= 1'b1; // sticky until reset
		end
	end
endmodule

// ==== rv_core.sv ====
// single-cycle rv64i core top level, connects decoder, architectural state and execution unit
`timescale 1ns/1ps

module rv_core #(
	parameter int              XLEN        = 64,
	parameter int              MEM_WORDS   = 256,
	parameter logic [XLEN-1:0] MTVEC_RESET = 'h100
) (
	input  logic            clk,
	input  logic            reset,
	input  logic [31:0]     inst,
	output logic [XLEN-1:0] pc,
	output logic            rd_wen,
	output logic [4:0]      rd,
	output logic [XLEN-1:0] x_rd,
	output logic [XLEN-1:0] dnpc,
	output logic            halt
);
	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;
	logic            is_ebreak;

	rv_idu #(.XLEN(XLEN)) idu_i (
		.inst   (inst),
		.opcode (opcode),
		.funct3 (funct3),
		.funct7 (funct7),
		.rs1    (rs1),
		.rs2    (rs2),
		.rd     (rd),
		.imm    (imm)
	);

	rv_arch_state #(.XLEN(XLEN)) state_i (
		.clk      (clk),
		.reset    (reset),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.rd_wen   (rd_wen),
		.halt_now (is_ebreak),
		.x_rd     (x_rd),
		.dnpc     (dnpc),
		.src1     (src1),
		.src2     (src2),
		.pc       (pc),
		.halted   (halt)
	);

	rv_exu #(.XLEN(XLEN), .MEM_WORDS(MEM_WORDS), .MTVEC_RESET(MTVEC_RESET)) exu_i (
		.clk       (clk),
		.reset     (reset),
		.halted    (halt),
		.inst      (inst),
		.opcode    (opcode),
		.funct3    (funct3),
		.funct7    (funct7),
		.rs1       (rs1),
		.rd        (rd),
		.imm       (imm),
		.src1      (src1),
		.src2      (src2),
		.pc        (pc),
		.rd_wen    (rd_wen),
		.x_rd      (x_rd),
		.dnpc      (dnpc),
		.is_ebreak (is_ebreak)
	);
endmodule

// ==== tb_clock.sv ====
// testbench clock and reset source, 20 ns period with reset held for the first 4 cycles
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);
	initial begin
		clk   = 1'b0;
		reset = 1'b1;
		forever #10 clk = ~clk;
	end

	initial begin
		repeat (4) @(posedge clk);
		reset <= 1'b0; // released on the 4th rising edge
	end
endmodule

// ==== tb_rv_core.sv ====
// testbench for rv_core, replays the traced program from rv_testdata.txt and checks each retire
`timescale 1ns/1ps

module tb_rv_core;
	localparam int XLEN      = 64;
	localparam int FIELDS    = 6;    // inst, pc, rd_wen, rd, x_rd, dnpc
	localparam int MAX_LINES = 128;

	logic            clk;
	logic            reset;
	logic [31:0]     inst;
	logic [XLEN-1:0] pc;
	logic            rd_wen;
	logic [4:0]      rd;
	logic [XLEN-1:0] x_rd;
	logic [XLEN-1:0] dnpc;
	logic            halt;

	logic [63:0] vectors [0:FIELDS*MAX_LINES-1];
	int          n_lines;
	int          errors;       // errors of the current line
	int          total_errors;
	int          failed_tests;
	int          cycles;
	int          cycle_limit;

	tb_clock clock_i (
		.clk   (clk),
		.reset (reset)
	);

	rv_core #(.XLEN(XLEN)) dut_i (
		.clk    (clk),
		.reset  (reset),
		.inst   (inst),
		.pc     (pc),
		.rd_wen (rd_wen),
		.rd     (rd),
		.x_rd   (x_rd),
		.dnpc   (dnpc),
		.halt   (halt)
	);

	task automatic check_xlen(input int line, input string name,
			input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("** Error line %0d: %s is %h, expected %h", line, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_reg(input int line, input string name,
			input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			$display("** Error line %0d: %s is %h, expected %h", line, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input int line, input string name,
			input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error line %0d: %s is %h, expected %h", line, name, got, exp);
			errors++;
		end
	endtask

	// watchdog, limit set once the vector count is known
	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the program did not finish", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		int   base;
		logic exp_halt;

		inst         = 32'h0000_0013; // nop during reset
		cycles       = 0;
		cycle_limit  = 0;
		total_errors = 0;
		failed_tests = 0;
		exp_halt     = 1'b0;
		for (int i = 0; i < FIELDS*MAX_LINES; i++)
			vectors[i] = 64'hffff_ffff;
		$readmemh("rv_testdata.txt", vectors);

		n_lines = 0;
		while (n_lines < MAX_LINES && vectors[n_lines*FIELDS] != 64'hffff_ffff)
			n_lines++;
		cycle_limit = 2*n_lines + 20;

		@(negedge clk);
		while (reset)
			@(negedge clk);

		for (int i = 0; i < n_lines; i++) begin
			base   = i*FIELDS;
			errors = 0;
			inst   = vectors[base][31:0];
			#5; // outputs settled, well ahead of the rising edge
			check_xlen(i, "pc", pc, vectors[base+1]);
			check_bit(i, "rd_wen", rd_wen, vectors[base+2][0]);
			check_reg(i, "rd", rd, vectors[base+3][4:0]);
			check_xlen(i, "x_rd", x_rd, vectors[base+4]);
			check_xlen(i, "dnpc", dnpc, vectors[base+5]);
			check_bit(i, "halt", halt, exp_halt);
			if (vectors[base][31:0] == 32'h0010_0073)
				exp_halt = 1'b1; // halt is visible from the next instruction on
			if (errors == 0) begin
				$display("line %0d pc %h inst %h ok", i, pc, inst);
			end else begin
				$display("line %0d pc %h inst %h failed with %0d errors", i, pc, inst, errors);
				failed_tests++;
			end
			total_errors += errors;
			@(negedge clk);
		end

		if (n_lines == 0) begin
			$display("no test vectors were read from rv_testdata.txt");
			failed_tests++;
		end

		$display("%0d tests, %0d failed, %0d errors", n_lines, failed_tests, total_errors);
		if (failed_tests == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end
endmodule

// ==== rv_testdata.txt ====
// columns: inst pc rd_wen rd x_rd dnpc, all hex, one line per executed instruction
// the last line (inst ffffffff) marks the end of the program
00500093 0 1 1 5 4
ffd00113 4 1 2 fffffffffffffffd 8
002081b3 8 1 3 2 c
40208233 c 1 4 8 10
001122b3 10 1 5 1 14
00113333 14 1 6 0 18
0f00c393 18 1 7 f5 1c
00411413 1c 1 8 ffffffffffffffd0 20
40115493 20 1 9 fffffffffffffffe 24
03c15513 24 1 a f 28
80000637 28 1 c ffffffff80000000 2c
fff6059b 2c 1 b 7fffffff 30
4046569b 30 1 d fffffffff8000000 34
40c0873b 34 1 e ffffffff80000005 38
00708013 38 1 0 c 3c
001007b3 3c 1 f 5 40
00208463 40 0 8 0 44
00209463 44 0 8 0 4c
00114463 4c 0 8 0 54
0020f463 54 0 8 0 58
00c0086f 58 1 10 5c 64
00000897 64 1 11 64 68
00c88967 68 1 12 6c 70
10000a13 70 1 14 100 74
002a3023 74 0 0 0 78
001a00a3 78 0 1 0 7c
007a1223 7c 0 4 0 80
00fa2423 80 0 8 0 84
001a0a83 84 1 15 5 88
000a0b03 88 1 16 fffffffffffffffd 8c
000a4b83 8c 1 17 fd 90
004a1c03 90 1 18 f5 94
002a5c83 94 1 19 ffff 98
000a2d03 98 1 1a ffffffffffff05fd 9c
004a6d83 9c 1 1b ffff00f5 a0
000a3e03 a0 1 1c ffff00f5ffff05fd a4
008a3e83 a4 1 1d 5 a8
20000293 a8 1 5 200 ac
30529373 ac 1 6 100 b0
00000073 b0 0 0 0 200
341023f3 200 1 7 b0 204
34203473 204 1 8 b 208
342064f3 208 1 9 b 20c
34203573 20c 1 a b 210
00438593 210 1 b b4 214
34159073 214 0 0 b0 218
30200073 218 0 0 0 b4
00100073 b4 0 0 0 b8
00100093 b4 0 1 1 b8
ffffffff 0 0 0 0 0

// ==== all.f ====
rv_pkg.sv
rv_idu.sv
rv_alu.sv
rv_csr_file.sv
rv_mau.sv
rv_exu.sv
rv_arch_state.sv
rv_core.sv
tb_clock.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
TOP       ?= tb_rv_core
FILELIST  ?= all.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir
